//--- include/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

`define MEM_ADDR_W 16   // byte address
`define MEM_DATA_W 32   // client word
`define MEM_BYTE_W 8    // ram data port

////////////////////////////////////////
// queue depths
////////////////////////////////////////

`define MEM_REQ_DEPTH 4
`define MEM_RSP_DEPTH 2

`endif

//--- src/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

    // owner of an access, carried through to the response
    typedef enum logic {
        src_fetch = 1'b0,
        src_lsu   = 1'b1
    } mem_src_e;

    ////////////////////////////////////////
    // client requests
    ////////////////////////////////////////

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
        logic                   is_store;
    } lsu_req_t;

    ////////////////////////////////////////
    // queued request and completion
    ////////////////////////////////////////

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;    // zero for fetches
        logic                   is_store;
        mem_src_e               src;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] data;     // load data, or the stored word
        logic                   is_store;
        mem_src_e               src;
    } mem_rsp_t;

endpackage

//--- src/mem_fifo.sv
`timescale 1ns/1ps

module mem_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t push_data,
    input  logic     push_valid,
    output logic     push_ready,
    output payload_t pop_data,
    output logic     pop_valid,
    input  logic     pop_ready
);

localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int cnt_w = $clog2(DEPTH + 1);

payload_t         mem [DEPTH];
logic [ptr_w-1:0] wr_ptr;
logic [ptr_w-1:0] rd_ptr;
logic [cnt_w-1:0] count;
logic             push;
logic             pop;

assign pop_valid  = (count != '0);
assign pop_data   = mem[rd_ptr];
assign push_ready = (count != cnt_w'(DEPTH)) || pop_ready;  // full but draining this cycle
assign push       = push_valid && push_ready;
assign pop        = pop_valid && pop_ready;

always_ff @(posedge clk) begin
    if (push) begin
        mem[wr_ptr] <= push_data;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end
end

endmodule

//--- src/mem_req_decode.sv
`timescale 1ns/1ps

module mem_req_decode (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::fetch_req_t fetch_req,
    input  logic                fetch_req_valid,
    output logic                fetch_req_ready,
    input  mem_pkg::lsu_req_t   lsu_req,
    input  logic                lsu_req_valid,
    output logic                lsu_req_ready,
    output mem_pkg::mem_req_t   req,
    output logic                req_valid,
    input  logic                req_ready
);

logic favour_lsu;  // round-robin flag, 0 gives fetch priority
logic sel_lsu;
logic contend;

assign contend = fetch_req_valid && lsu_req_valid;
assign sel_lsu = lsu_req_valid && (!fetch_req_valid || favour_lsu);

assign req_valid = fetch_req_valid || lsu_req_valid;

// the loser of a contended cycle sees ready low
assign fetch_req_ready = req_ready && (!lsu_req_valid || !favour_lsu);
assign lsu_req_ready   = req_ready && (!fetch_req_valid || favour_lsu);

////////////////////////////////////////
// tag and merge
////////////////////////////////////////

always_comb begin
    if (sel_lsu) begin
        req.addr     = lsu_req.addr;
        req.wdata    = lsu_req.wdata;
        req.is_store = lsu_req.is_store;
        req.src      = mem_pkg::src_lsu;
    end else begin
        req.addr     = fetch_req.addr;
        req.wdata    = '0;
        req.is_store = 1'b0;  // fetches are always reads
        req.src      = mem_pkg::src_fetch;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        favour_lsu <= 1'b0;
    end else if (contend && req_ready) begin
        favour_lsu <= !favour_lsu;
    end
end

endmodule

//--- src/mem_byte_exec.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_byte_exec (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_pkg::mem_req_t      req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output mem_pkg::mem_rsp_t      rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output logic [`MEM_ADDR_W-1:0] ram_addr,
    output logic [`MEM_BYTE_W-1:0] ram_wdata,
    output logic                   ram_we,
    input  logic [`MEM_BYTE_W-1:0] ram_rdata
);

localparam int addr_w     = `MEM_ADDR_W;
localparam int last_phase = 4;

logic                   busy;
logic [2:0]             phase;      // 0..3 byte slots, 4 response slot
logic                   held;       // response waiting on rsp_ready
logic [`MEM_ADDR_W-1:0] base_addr;
logic                   is_store;
mem_pkg::mem_src_e      src;
logic [`MEM_DATA_W-1:0] word;       // store rotator / load shifter
logic [`MEM_DATA_W-1:0] load_word;
logic                   pop;
logic                   done;

assign rsp_valid = busy && (phase == 3'(last_phase));
assign done      = rsp_valid && rsp_ready;
assign req_ready = !busy || done;
assign pop       = req_valid && req_ready;

// newest byte enters at the top, byte 0 ends up in bits 7:0
assign load_word = {ram_rdata, word[`MEM_DATA_W-1:`MEM_BYTE_W]};

////////////////////////////////////////
// ram port
////////////////////////////////////////

assign ram_addr  = base_addr + addr_w'(phase[1:0]);  // wraps at top of space
assign ram_wdata = word[`MEM_BYTE_W-1:0];
assign ram_we    = busy && is_store && !phase[2];

always_comb begin
    rsp.data     = (is_store || held) ? word : load_word;
    rsp.is_store = is_store;
    rsp.src      = src;
end

////////////////////////////////////////
// sequencer
////////////////////////////////////////

always_ff @(posedge clk) begin
    if (rst) begin
        busy  <= 1'b0;
        phase <= '0;
        held  <= 1'b0;
    end else if (pop) begin
        busy  <= 1'b1;
        phase <= '0;
        held  <= 1'b0;
    end else if (done) begin
        busy <= 1'b0;
        held <= 1'b0;
    end else if (busy && !phase[2]) begin
        phase <= phase + 1'b1;
    end else if (rsp_valid) begin
        held <= 1'b1;  // response fifo full
    end
end

always_ff @(posedge clk) begin
    if (pop) begin
        base_addr <= req.addr;
        is_store  <= req.is_store;
        src       <= req.src;
        word      <= req.wdata;
    end else if (busy && !held) begin
        if (is_store && !phase[2]) begin
            // rotate so the next byte sits low, word is whole again after 4
            word <= {word[`MEM_BYTE_W-1:0], word[`MEM_DATA_W-1:`MEM_BYTE_W]};
        end else if (!is_store && phase != 3'd0) begin
            word <= load_word;  // byte from previous cycle's address
        end
    end
end

endmodule

//--- src/mem_result.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_result (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_rsp_t rsp_in,
    input  logic              rsp_in_valid,
    output logic              rsp_in_ready,
    output mem_pkg::mem_rsp_t fetch_rsp,
    output logic              fetch_rsp_valid,
    input  logic              fetch_rsp_ready,
    output mem_pkg::mem_rsp_t lsu_rsp,
    output logic              lsu_rsp_valid,
    input  logic              lsu_rsp_ready
);

mem_pkg::mem_rsp_t head;
logic              head_valid;
logic              head_ready;
logic              to_fetch;

////////////////////////////////////////
// completion queue
////////////////////////////////////////

mem_fifo #(
    .payload_t (mem_pkg::mem_rsp_t),
    .DEPTH     (`MEM_RSP_DEPTH)
) u_rsp_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_data  (rsp_in),
    .push_valid (rsp_in_valid),
    .push_ready (rsp_in_ready),
    .pop_data   (head),
    .pop_valid  (head_valid),
    .pop_ready  (head_ready)
);

////////////////////////////////////////
// routing
////////////////////////////////////////

assign to_fetch = (head.src == mem_pkg::src_fetch);

assign fetch_rsp       = head;
assign lsu_rsp         = head;
assign fetch_rsp_valid = head_valid && to_fetch;
assign lsu_rsp_valid   = head_valid && !to_fetch;

// in-order, so a stalled port holds up the other one
assign head_ready = to_fetch ? fetch_rsp_ready : lsu_rsp_ready;

endmodule

//--- src/mem_ctrl_top.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_ctrl_top (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_pkg::fetch_req_t    fetch_req,
    input  logic                   fetch_req_valid,
    output logic                   fetch_req_ready,
    input  mem_pkg::lsu_req_t      lsu_req,
    input  logic                   lsu_req_valid,
    output logic                   lsu_req_ready,
    output mem_pkg::mem_rsp_t      fetch_rsp,
    output logic                   fetch_rsp_valid,
    input  logic                   fetch_rsp_ready,
    output mem_pkg::mem_rsp_t      lsu_rsp,
    output logic                   lsu_rsp_valid,
    input  logic                   lsu_rsp_ready,
    output logic [`MEM_ADDR_W-1:0] ram_addr,
    output logic [`MEM_BYTE_W-1:0] ram_wdata,
    output logic                   ram_we,
    input  logic [`MEM_BYTE_W-1:0] ram_rdata
);

mem_pkg::mem_req_t dec_req;
logic              dec_req_valid;
logic              dec_req_ready;
mem_pkg::mem_req_t q_req;
logic              q_req_valid;
logic              q_req_ready;
mem_pkg::mem_rsp_t ex_rsp;
logic              ex_rsp_valid;
logic              ex_rsp_ready;

mem_req_decode u_decode (
    .clk             (clk),
    .rst             (rst),
    .fetch_req       (fetch_req),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req_ready (fetch_req_ready),
    .lsu_req         (lsu_req),
    .lsu_req_valid   (lsu_req_valid),
    .lsu_req_ready   (lsu_req_ready),
    .req             (dec_req),
    .req_valid       (dec_req_valid),
    .req_ready       (dec_req_ready)
);

mem_fifo #(
    .payload_t (mem_pkg::mem_req_t),
    .DEPTH     (`MEM_REQ_DEPTH)
) u_req_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_data  (dec_req),
    .push_valid (dec_req_valid),
    .push_ready (dec_req_ready),
    .pop_data   (q_req),
    .pop_valid  (q_req_valid),
    .pop_ready  (q_req_ready)
);

mem_byte_exec u_exec (
    .clk       (clk),
    .rst       (rst),
    .req       (q_req),
    .req_valid (q_req_valid),
    .req_ready (q_req_ready),
    .rsp       (ex_rsp),
    .rsp_valid (ex_rsp_valid),
    .rsp_ready (ex_rsp_ready),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_we    (ram_we),
    .ram_rdata (ram_rdata)
);

mem_result u_result (
    .clk             (clk),
    .rst             (rst),
    .rsp_in          (ex_rsp),
    .rsp_in_valid    (ex_rsp_valid),
    .rsp_in_ready    (ex_rsp_ready),
    .fetch_rsp       (fetch_rsp),
    .fetch_rsp_valid (fetch_rsp_valid),
    .fetch_rsp_ready (fetch_rsp_ready),
    .lsu_rsp         (lsu_rsp),
    .lsu_rsp_valid   (lsu_rsp_valid),
    .lsu_rsp_ready   (lsu_rsp_ready)
);

endmodule

//--- tests/byte_ram_model.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module byte_ram_model (
    input  logic                   clk,
    input  logic [`MEM_ADDR_W-1:0] addr,
    input  logic [`MEM_BYTE_W-1:0] wdata,
    input  logic                   we,
    output logic [`MEM_BYTE_W-1:0] rdata
);

localparam int aw    = `MEM_ADDR_W;
localparam int depth = 1 << `MEM_ADDR_W;

logic [`MEM_BYTE_W-1:0] mem [depth];

// both address bytes take part in the power-up contents
function automatic logic [`MEM_BYTE_W-1:0] pattern(input logic [aw-1:0] a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3c;
endfunction

initial begin
    for (int i = 0; i < depth; i++) begin
        mem[i] = pattern(aw'(i));
    end
end

always @(posedge clk) begin
    if (we) begin
        mem[addr] <= wdata;
    end
    rdata <= mem[addr];  // old byte on a write
end

endmodule

//--- tests/mem_ctrl_tb.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_ctrl_tb;

localparam int          clk_period  = 40;
localparam int          drive_delay = 1;
localparam int          wait_limit  = 100;  // cycles per wait
localparam logic [15:0] lfsr_seed   = 16'd92;
localparam int          aw          = `MEM_ADDR_W;
localparam int          depth       = 1 << `MEM_ADDR_W;

logic                   clk;
logic                   rst;
mem_pkg::fetch_req_t    fetch_req;
logic                   fetch_req_valid;
logic                   fetch_req_ready;
mem_pkg::lsu_req_t      lsu_req;
logic                   lsu_req_valid;
logic                   lsu_req_ready;
mem_pkg::mem_rsp_t      fetch_rsp;
logic                   fetch_rsp_valid;
logic                   fetch_rsp_ready;
mem_pkg::mem_rsp_t      lsu_rsp;
logic                   lsu_rsp_valid;
logic                   lsu_rsp_ready;
logic [`MEM_ADDR_W-1:0] ram_addr;
logic [`MEM_BYTE_W-1:0] ram_wdata;
logic                   ram_we;
logic [`MEM_BYTE_W-1:0] ram_rdata;

logic [`MEM_BYTE_W-1:0] sb_mem [depth];  // mirror of the ram
logic [15:0]            lfsr;
int                     check_errors;
int                     timeouts;

mem_ctrl_top u_mem_ctrl_top (
    .clk             (clk),
    .rst             (rst),
    .fetch_req       (fetch_req),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req_ready (fetch_req_ready),
    .lsu_req         (lsu_req),
    .lsu_req_valid   (lsu_req_valid),
    .lsu_req_ready   (lsu_req_ready),
    .fetch_rsp       (fetch_rsp),
    .fetch_rsp_valid (fetch_rsp_valid),
    .fetch_rsp_ready (fetch_rsp_ready),
    .lsu_rsp         (lsu_rsp),
    .lsu_rsp_valid   (lsu_rsp_valid),
    .lsu_rsp_ready   (lsu_rsp_ready),
    .ram_addr        (ram_addr),
    .ram_wdata       (ram_wdata),
    .ram_we          (ram_we),
    .ram_rdata       (ram_rdata)
);

byte_ram_model u_byte_ram_model (
    .clk   (clk),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .we    (ram_we),
    .rdata (ram_rdata)
);

initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
end

////////////////////////////////////////
// scoreboard and lfsr
////////////////////////////////////////

function automatic logic [7:0] fill_byte(input logic [aw-1:0] a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3c;
endfunction

// little-endian, byte 0 at the address, wrapping at the top
function automatic logic [31:0] predict_word(input logic [aw-1:0] a);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
        w[8*i +: 8] = sb_mem[a + aw'(i)];
    end
    return w;
endfunction

function automatic void record_store(input logic [aw-1:0] a, input logic [31:0] d);
    for (int i = 0; i < 4; i++) begin
        sb_mem[a + aw'(i)] = d[8*i +: 8];
    end
endfunction

function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        v    = {v[30:0], fb};
    end
    return v;
endfunction

////////////////////////////////////////
// checks and handshakes
////////////////////////////////////////

function automatic void report_timeout(input string what);
    timeouts++;
    $display("timed out after %0d cycles waiting for %s", wait_limit, what);
endfunction

function automatic void expect_rsp(input mem_pkg::mem_rsp_t r, input logic [31:0] exp_data,
                                   input logic exp_store, input mem_pkg::mem_src_e exp_src,
                                   input string what);
    assert (r.data == exp_data && r.is_store == exp_store && r.src == exp_src) else begin
        check_errors++;
        $display("ERROR at %0t ns: %s gave data %h store %b src %0d, expected %h %b %0d",
                 $time, what, r.data, r.is_store, r.src, exp_data, exp_store, exp_src);
    end
endfunction

function automatic void check_idle(input string what);
    assert (!fetch_rsp_valid && !lsu_rsp_valid && !ram_we && fetch_req_ready && lsu_req_ready)
    else begin
        check_errors++;
        $display("ERROR at %0t ns: %s rsp valids %b %b, ram_we %b, req readies %b %b",
                 $time, what, fetch_rsp_valid, lsu_rsp_valid, ram_we,
                 fetch_req_ready, lsu_req_ready);
    end
endfunction

task automatic send_fetch(input logic [aw-1:0] a);
    int n;
    n                = 0;
    fetch_req.addr   = a;
    fetch_req_valid  = 1'b1;
    do begin
        @(negedge clk);
        n++;
    end while (!fetch_req_ready && n < wait_limit);
    if (!fetch_req_ready) begin
        report_timeout("fetch_req_ready");
    end
    @(posedge clk);
    #(drive_delay);
    fetch_req_valid = 1'b0;
endtask

task automatic send_lsu(input logic [aw-1:0] a, input logic [31:0] d, input logic st);
    int n;
    n             = 0;
    lsu_req       = '{addr: a, wdata: d, is_store: st};
    lsu_req_valid = 1'b1;
    do begin
        @(negedge clk);
        n++;
    end while (!lsu_req_ready && n < wait_limit);
    if (!lsu_req_ready) begin
        report_timeout("lsu_req_ready");
    end
    @(posedge clk);
    #(drive_delay);
    lsu_req_valid = 1'b0;
endtask

task automatic recv_fetch(output mem_pkg::mem_rsp_t r, input logic lsu_quiet);
    int n;
    n               = 0;
    fetch_rsp_ready = 1'b1;
    do begin
        @(negedge clk);
        n++;
        if (lsu_quiet) begin
            assert (!lsu_rsp_valid) else begin
                check_errors++;
                $display("ERROR at %0t ns: lsu port valid while only a fetch is open", $time);
            end
        end
    end while (!fetch_rsp_valid && n < wait_limit);
    if (!fetch_rsp_valid) begin
        report_timeout("a response on the fetch port");
    end
    r = fetch_rsp;
    @(posedge clk);
    #(drive_delay);
    fetch_rsp_ready = 1'b0;
endtask

task automatic recv_lsu(output mem_pkg::mem_rsp_t r);
    int n;
    n             = 0;
    lsu_rsp_ready = 1'b1;
    do begin
        @(negedge clk);
        n++;
    end while (!lsu_rsp_valid && n < wait_limit);
    if (!lsu_rsp_valid) begin
        report_timeout("a response on the lsu port");
    end
    r = lsu_rsp;
    @(posedge clk);
    #(drive_delay);
    lsu_rsp_ready = 1'b0;
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic reset_and_check_idle();
    rst = 1'b1;
    for (int i = 0; i < 5; i++) begin
        @(posedge clk);
        if (i < 4) begin
            @(negedge clk);
            check_idle("during reset");
        end
    end
    #(drive_delay);
    rst = 1'b0;
    @(negedge clk);
    check_idle("after reset");
    @(posedge clk);
    #(drive_delay);
endtask

task automatic store_then_load();
    mem_pkg::mem_rsp_t r;
    send_lsu(16'h0040, 32'hcafe_f00d, 1'b1);
    record_store(16'h0040, 32'hcafe_f00d);
    recv_lsu(r);
    expect_rsp(r, 32'hcafe_f00d, 1'b1, mem_pkg::src_lsu, "store completion");
    send_lsu(16'h0040, '0, 1'b0);
    recv_lsu(r);
    expect_rsp(r, predict_word(16'h0040), 1'b0, mem_pkg::src_lsu, "load after store");
endtask

task automatic fetch_sees_store();
    mem_pkg::mem_rsp_t r;
    send_lsu(16'h0123, 32'h4433_2211, 1'b1);  // unaligned
    record_store(16'h0123, 32'h4433_2211);
    recv_lsu(r);
    expect_rsp(r, 32'h4433_2211, 1'b1, mem_pkg::src_lsu, "store before fetch");
    send_fetch(16'h0123);
    recv_fetch(r, 1'b1);
    expect_rsp(r, 32'h4433_2211, 1'b0, mem_pkg::src_fetch, "fetch of stored word");
    send_fetch(16'h0121);  // bytes 11 and 22 land in the upper half
    recv_fetch(r, 1'b1);
    expect_rsp(r, predict_word(16'h0121), 1'b0, mem_pkg::src_fetch, "overlapping fetch");
endtask

task automatic mixed_clients();
    mem_pkg::mem_rsp_t rs;
    mem_pkg::mem_rsp_t rf;
    mem_pkg::mem_rsp_t rl;
    send_lsu(16'h0200, 32'h0bad_c0de, 1'b1);
    record_store(16'h0200, 32'h0bad_c0de);
    recv_lsu(rs);
    expect_rsp(rs, 32'h0bad_c0de, 1'b1, mem_pkg::src_lsu, "setup store");
    send_lsu(16'h0300, 32'h8765_4321, 1'b1);
    record_store(16'h0300, 32'h8765_4321);
    recv_lsu(rs);
    expect_rsp(rs, 32'h8765_4321, 1'b1, mem_pkg::src_lsu, "setup store");
    fork
        for (int i = 0; i < 6; i++) send_fetch(16'h0200 + aw'(i));
        for (int i = 0; i < 6; i++) send_lsu(16'h0300 + aw'(2 * i), '0, 1'b0);
        for (int i = 0; i < 6; i++) begin
            recv_fetch(rf, 1'b0);
            expect_rsp(rf, predict_word(16'h0200 + aw'(i)), 1'b0, mem_pkg::src_fetch,
                       "contended fetch");
        end
        for (int i = 0; i < 6; i++) begin
            recv_lsu(rl);
            expect_rsp(rl, predict_word(16'h0300 + aw'(2 * i)), 1'b0, mem_pkg::src_lsu,
                       "contended load");
        end
    join
endtask

task automatic hold_lsu_response();
    mem_pkg::mem_rsp_t first;
    mem_pkg::mem_rsp_t r;
    int                n;
    n = 0;
    for (int i = 0; i < 4; i++) begin
        send_lsu(16'h0400 + aw'(3 * i), '0, 1'b0);
    end
    do begin
        @(negedge clk);
        n++;
    end while (!lsu_rsp_valid && n < wait_limit);
    if (!lsu_rsp_valid) begin
        report_timeout("the stalled lsu response");
    end
    first = lsu_rsp;
    repeat (20) begin
        @(negedge clk);
        assert (lsu_rsp_valid && lsu_rsp == first) else begin
            check_errors++;
            $display("ERROR at %0t ns: stalled lsu response changed or dropped", $time);
        end
    end
    @(posedge clk);
    #(drive_delay);
    expect_rsp(first, predict_word(16'h0400), 1'b0, mem_pkg::src_lsu, "stalled head");
    for (int i = 0; i < 4; i++) begin
        recv_lsu(r);
        expect_rsp(r, predict_word(16'h0400 + aw'(3 * i)), 1'b0, mem_pkg::src_lsu,
                   "load after stall");
    end
endtask

task automatic random_traffic();
    mem_pkg::mem_rsp_t r;
    logic [aw-1:0]     a;
    logic [31:0]       d;
    logic [31:0]       coin;
    logic              st;
    for (int k = 0; k < 32; k++) begin
        coin = lfsr_bits(1);
        if (coin[0]) begin
            a = 16'hfffd + aw'(lfsr_bits(3));  // may wrap past the top
        end else begin
            a = 16'h0800 + aw'(lfsr_bits(3));
        end
        coin = lfsr_bits(1);
        st   = coin[0];
        d    = lfsr_bits(32);
        send_lsu(a, d, st);
        if (st) begin
            record_store(a, d);
        end
        recv_lsu(r);
        expect_rsp(r, st ? d : predict_word(a), st, mem_pkg::src_lsu, "random access");
    end
endtask

initial begin
    check_errors    = 0;
    timeouts        = 0;
    lfsr            = lfsr_seed;
    rst             = 1'b1;
    fetch_req       = '0;
    fetch_req_valid = 1'b0;
    lsu_req         = '0;
    lsu_req_valid   = 1'b0;
    fetch_rsp_ready = 1'b0;
    lsu_rsp_ready   = 1'b0;
    for (int i = 0; i < depth; i++) begin
        sb_mem[i] = fill_byte(aw'(i));
    end
    reset_and_check_idle();
    store_then_load();
    fetch_sees_store();
    mixed_clients();
    hold_lsu_response();
    random_traffic();
    $display("wrong values %0d, timeouts %0d", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
        $display("TESTS PASSED");
    end else begin
        $display("TESTS FAILED");
    end
    $finish;
end

endmodule

//--- sources.f
+incdir+include
src/mem_pkg.sv
src/mem_fifo.sv
src/mem_req_decode.sv
src/mem_byte_exec.sv
src/mem_result.sv
src/mem_ctrl_top.sv
tests/byte_ram_model.sv
tests/mem_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory controller testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=mem_ctrl_sim
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module mem_ctrl_tb \
    --Mdir "${build_dir}" \
    -o "${sim_bin}"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./${build_dir}/${sim_bin}" > "${log_file}" 2>&1
run_status=$?
cat "${log_file}"
if [ ${run_status} -ne 0 ]; then
    echo "simulation exited with status ${run_status}"
    exit 1
fi

if grep -qx "TESTS PASSED" "${log_file}"; then
    exit 0
fi
echo "pass message not found in ${log_file}"
exit 1
